/* design/context_manager.sv */
`include "core_macros.svh"

`default_nettype none

module context_manager
    import core_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  logic                       next_pc_ready,
    input  logic                       branch,
    input  logic [`LEN_WORD-1:0]       next_pc,
    input  logic [`LEN_WORD-1:0]       next_pc_f,
    input  logic [`LEN_WINDOW_CNT-1:0] window_count,
    output logic                       fetch_req,
    output logic [`LEN_WORD-1:0]       fetch_addr,
    output logic [`LEN_WORD-1:0]       cur_pc,
    output logic [`LEN_CONTEXT-1:0]    cur_context,
    output logic [`LEN_CONTEXT-1:0]    context_b_t,
    output logic [`LEN_CONTEXT-1:0]    context_b_f,
    output logic                       order,
    output logic                       idle
);

    logic [`NUM_CONTEXT-1:0] active;
    logic [`LEN_WORD-1:0]    pc_tab [`NUM_CONTEXT];
    fetch_t                  in_flight;
    logic                    in_flight_valid;
    logic [`LEN_CONTEXT-1:0] rr_last;
    logic [`LEN_CONTEXT-1:0] pick;
    logic                    pick_valid;
    logic [`LEN_CONTEXT:0]   free_count;
    logic                    free_ok;
    logic                    room;

    assign cur_pc      = in_flight.pc;
    assign cur_context = in_flight.context_id;
    assign context_b_f = in_flight.context_id;
    assign order       = instr_valid & in_flight_valid;
    assign idle        = ~|active & ~in_flight_valid;

    // lowest free context.
    always_comb begin
        context_b_t = '0;
        free_count  = '0;
        for (int i = `NUM_CONTEXT - 1; i >= 0; i--) begin
            if (!active[i]) begin
                context_b_t = i[`LEN_CONTEXT-1:0];
                free_count  = free_count + 1'b1;
            end
        end
    end

    // round robin after the last issued context.
    always_comb begin
        logic [`LEN_CONTEXT-1:0] cand;
        pick       = rr_last;
        pick_valid = 1'b0;
        for (int k = `NUM_CONTEXT; k >= 1; k--) begin
            cand = rr_last + k[`LEN_CONTEXT-1:0];
            if (active[cand] && !(in_flight_valid && in_flight.context_id == cand)) begin
                pick       = cand;
                pick_valid = 1'b1;
            end
        end
    end

    // spare a free context for a branch in decode, else fetch one at a time.
    assign free_ok    = ~order | (free_count > {{`LEN_CONTEXT{1'b0}}, order});
    assign room       = (window_count + {{(`LEN_WINDOW_CNT-1){1'b0}}, order}) < `WINDOW_DEPTH;
    assign fetch_req  = pick_valid & free_ok & room;
    assign fetch_addr = pc_tab[pick];

    always_ff @(posedge clk) begin
        if (fetch_req) begin
            in_flight.context_id <= pick;
            in_flight.pc         <= pc_tab[pick];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active          <= `NUM_CONTEXT'(1);
            in_flight_valid <= 1'b0;
            rr_last         <= '1;
            for (int i = 0; i < `NUM_CONTEXT; i++) begin
                pc_tab[i] <= '0;
            end
        end else begin
            in_flight_valid <= fetch_req;  // dropped when the load port wins.
            if (fetch_req) begin
                rr_last <= pick;
            end
            if (order) begin
                if (next_pc_ready) begin
                    pc_tab[cur_context] <= next_pc;
                end else if (branch) begin
                    if (free_count != '0) begin
                        active[context_b_t] <= 1'b1;  // taken path.
                        pc_tab[context_b_t] <= next_pc;
                        pc_tab[cur_context] <= next_pc_f;
                    end
                end else begin
                    active[cur_context] <= 1'b0;  // jalr or unknown opcode.
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ==============================
// datapath widths
// ==============================
`define LEN_WORD        32
`define LEN_INST        32
`define LEN_OPCODE      7
`define LEN_FUNC3       3
`define LEN_FUNC7       7
`define LEN_VREG        6

// ==============================
// contexts and storage
// ==============================
`define NUM_CONTEXT     4
`define LEN_CONTEXT     $clog2(`NUM_CONTEXT)
`define WINDOW_DEPTH    8
`define LEN_WINDOW_PTR  $clog2(`WINDOW_DEPTH)
`define LEN_WINDOW_CNT  $clog2(`WINDOW_DEPTH + 1)
`define IMEM_WORDS      256
`define LEN_IMEM_ADDR   $clog2(`IMEM_WORDS)

`endif

/* design/core_pkg.sv */
`include "core_macros.svh"

`default_nettype none

package core_pkg;

    typedef enum logic [`LEN_OPCODE-1:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_MEML   = 7'b0000011,
        OP_MEMS   = 7'b0100011,
        OP_ALUI   = 7'b0010011,
        OP_ALU    = 7'b0110011,
        OP_FMEML  = 7'b0000111,
        OP_FMEMS  = 7'b0100111,
        OP_FPU    = 7'b1010011,
        OP_INPUT  = 7'b0001011,  // custom-0.
        OP_OUTPUT = 7'b0101011   // custom-1.
    } opcode_e;

    typedef enum logic [3:0] {
        EX_ALU,
        EX_ALU_EXT,
        EX_FPU,
        EX_MEM,
        EX_JUMP,
        EX_BRANCH,
        EX_SUBST,
        EX_IO,
        EX_NONE
    } exec_type_e;

    typedef struct packed {
        logic                 used;
        logic [`LEN_VREG-1:0] addr;  // float bit over 5-bit index.
    } vreg_t;

    typedef struct packed {
        exec_type_e              exec_type;
        vreg_t                   rs1;
        vreg_t                   rs2;
        vreg_t                   rd;
        logic [`LEN_WORD-1:0]    imm;
        logic                    io_type;
        logic [`LEN_FUNC3-1:0]   func3;
        logic [`LEN_FUNC7-1:0]   func7;
        logic [`LEN_WORD-1:0]    pc;
        logic [`LEN_CONTEXT-1:0] context_id;
        logic [`LEN_CONTEXT-1:0] context_b_t;
        logic [`LEN_CONTEXT-1:0] context_b_f;
    } dec_entry_t;

    typedef struct packed {
        logic [`LEN_CONTEXT-1:0] context_id;
        logic [`LEN_WORD-1:0]    pc;
    } fetch_t;

endpackage

`default_nettype wire

/* design/decode.sv */
`include "core_macros.svh"

`default_nettype none

module decode
    import core_pkg::*;
(
    input  logic                    order,
    input  logic [`LEN_INST-1:0]    instr,
    input  logic [`LEN_WORD-1:0]    pc,
    input  logic [`LEN_CONTEXT-1:0] context_in,
    input  logic [`LEN_CONTEXT-1:0] context_b_t,
    input  logic [`LEN_CONTEXT-1:0] context_b_f,
    output logic                    next_pc_ready,
    output logic                    branch,
    output logic [`LEN_WORD-1:0]    next_pc,
    output logic [`LEN_WORD-1:0]    next_pc_f,
    output dec_entry_t              dec_entry
);

    opcode_e               opcode;
    exec_type_e            exec_type;
    logic [`LEN_FUNC3-1:0] func3;
    logic [`LEN_FUNC7-1:0] func7;
    logic                  is_mem;
    logic                  is_io;
    logic                  is_float;
    logic                  rs1_float;
    logic                  rd_float;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  use_rd;
    logic [`LEN_WORD-1:0]  pc_plus4;
    logic [`LEN_WORD-1:0]  imm_i;
    logic [`LEN_WORD-1:0]  imm_s;
    logic [`LEN_WORD-1:0]  imm_b;
    logic [`LEN_WORD-1:0]  imm_j;
    logic [`LEN_WORD-1:0]  imm_u;
    logic [`LEN_WORD-1:0]  imm;

    assign opcode = opcode_e'(instr[6:0]);

    // ==============================
    // classification
    // ==============================
    always_comb begin
        case (opcode)
            OP_ALU:                               exec_type = instr[25] ? EX_ALU_EXT : EX_ALU;
            OP_ALUI:                              exec_type = EX_ALU;
            OP_FPU:                               exec_type = EX_FPU;
            OP_MEML, OP_MEMS, OP_FMEML, OP_FMEMS: exec_type = EX_MEM;
            OP_JALR:                              exec_type = EX_JUMP;
            OP_BRANCH:                            exec_type = EX_BRANCH;
            OP_LUI, OP_AUIPC, OP_JAL:             exec_type = EX_SUBST;
            OP_INPUT, OP_OUTPUT:                  exec_type = EX_IO;
            default:                              exec_type = EX_NONE;
        endcase
    end

    assign is_mem = (exec_type == EX_MEM);
    assign is_io  = (exec_type == EX_IO);
    assign branch = (exec_type == EX_BRANCH);

    assign func3 = (exec_type == EX_SUBST) ? '0 : instr[14:12];  // u and j types.
    assign func7 = ((exec_type inside {EX_MEM, EX_JUMP, EX_BRANCH, EX_SUBST})
                    || (opcode == OP_ALUI && func3[1:0] != 2'b01)) ? '0 : instr[31:25];

    // ==============================
    // register operands
    // ==============================
    assign is_float  = (opcode inside {OP_FPU, OP_FMEML, OP_FMEMS}) | (is_io & func7[5]);
    assign rs1_float = is_float & ~is_mem & (~func7[6] | (func7[3] ^ func7[4]) | is_io);
    assign rd_float  = is_float & (~func7[6] | ~(func7[3] ^ func7[4]) | is_io);

    assign use_rd  = ~(opcode inside {OP_MEMS, OP_FMEMS, OP_OUTPUT, OP_BRANCH});
    assign use_rs1 = ~(opcode inside {OP_LUI, OP_JAL, OP_AUIPC, OP_INPUT});
    assign use_rs2 = (opcode inside {OP_ALU, OP_BRANCH, OP_MEMS, OP_FMEMS})
                   | (opcode == OP_FPU && !func7[5]);

    // ==============================
    // immediates
    // ==============================
    assign pc_plus4 = pc + 32'd4;
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        case (opcode)
            OP_ALUI, OP_MEML, OP_FMEML: imm = imm_i;
            OP_MEMS, OP_FMEMS:          imm = imm_s;
            OP_JAL, OP_JALR:            imm = pc_plus4;  // link value.
            OP_LUI:                     imm = imm_u;
            OP_AUIPC:                   imm = pc + imm_u;
            default:                    imm = '0;
        endcase
    end

    always_comb begin
        dec_entry.exec_type   = exec_type;
        dec_entry.rs1.used    = use_rs1;
        dec_entry.rs1.addr    = use_rs1 ? {rs1_float, instr[19:15]} : '0;
        dec_entry.rs2.used    = use_rs2;
        dec_entry.rs2.addr    = use_rs2 ? {is_float, instr[24:20]} : '0;
        dec_entry.rd.used     = use_rd;
        dec_entry.rd.addr     = use_rd ? {rd_float, instr[11:7]} : '0;
        dec_entry.imm         = imm;
        dec_entry.io_type     = (is_io | is_mem) & instr[5];  // store or output.
        dec_entry.func3       = func3;
        dec_entry.func7       = func7;
        dec_entry.pc          = pc;
        dec_entry.context_id  = context_in;
        dec_entry.context_b_t = context_b_t;
        dec_entry.context_b_f = context_b_f;
    end

    // next pc is known here except for jalr.
    assign next_pc_ready = order
        & (exec_type inside {EX_ALU, EX_ALU_EXT, EX_FPU, EX_MEM, EX_SUBST, EX_IO});
    assign next_pc   = (opcode == OP_JAL) ? pc + imm_j :
                       branch             ? pc + imm_b :
                                            pc_plus4;
    assign next_pc_f = pc_plus4;

endmodule

`default_nettype wire

/* design/frontend_top.sv */
`include "core_macros.svh"

`default_nettype none

module frontend_top
    import core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_en,
    input  logic [`LEN_WORD-1:0] load_addr,
    input  logic [`LEN_INST-1:0] load_data,
    input  logic                 pop,
    output dec_entry_t           head,
    output logic                 not_empty,
    output logic                 idle
);

    logic                       fetch_req;
    logic [`LEN_WORD-1:0]       fetch_addr;
    logic                       instr_valid;
    logic [`LEN_INST-1:0]       instr;
    logic [`LEN_WORD-1:0]       cur_pc;
    logic [`LEN_CONTEXT-1:0]    cur_context;
    logic [`LEN_CONTEXT-1:0]    context_b_t;
    logic [`LEN_CONTEXT-1:0]    context_b_f;
    logic                       order;
    logic                       next_pc_ready;
    logic                       branch;
    logic [`LEN_WORD-1:0]       next_pc;
    logic [`LEN_WORD-1:0]       next_pc_f;
    dec_entry_t                 dec_entry;
    logic [`LEN_WINDOW_CNT-1:0] window_count;

    instr_store u_store (.*);

    context_manager u_ctx (.*);

    decode u_decode (
        .*,
        .pc         (cur_pc),
        .context_in (cur_context)
    );

    inst_window u_window (
        .*,
        .push       (instr_valid),
        .push_entry (dec_entry),
        .count      (window_count)
    );

endmodule

`default_nettype wire

/* design/inst_window.sv */
`include "core_macros.svh"

`default_nettype none

module inst_window
    import core_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  dec_entry_t                 push_entry,
    input  logic                       pop,
    output dec_entry_t                 head,
    output logic                       not_empty,
    output logic [`LEN_WINDOW_CNT-1:0] count
);

    dec_entry_t                 entries [`WINDOW_DEPTH];
    logic [`LEN_WINDOW_PTR-1:0] wr_ptr;
    logic [`LEN_WINDOW_PTR-1:0] rd_ptr;
    logic                       full;
    logic                       do_push;
    logic                       do_pop;

    assign full      = (count == `WINDOW_DEPTH);
    assign not_empty = (count != '0);
    assign do_pop    = pop & not_empty;
    assign do_push   = push & (~full | do_pop);
    assign head      = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/instr_store.sv */
`include "core_macros.svh"

`default_nettype none

module instr_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_en,
    input  logic [`LEN_WORD-1:0] load_addr,
    input  logic [`LEN_INST-1:0] load_data,
    input  logic                 fetch_req,
    input  logic [`LEN_WORD-1:0] fetch_addr,
    output logic                 instr_valid,
    output logic [`LEN_INST-1:0] instr
);

    logic [`LEN_INST-1:0]      mem [`IMEM_WORDS];
    logic                      grant_load;
    logic                      grant_fetch;
    logic [`LEN_IMEM_ADDR-1:0] load_idx;
    logic [`LEN_IMEM_ADDR-1:0] fetch_idx;

    // fixed priority, load port first.
    assign grant_load  = load_en;
    assign grant_fetch = fetch_req & ~load_en;

    assign load_idx  = load_addr[`LEN_IMEM_ADDR+1:2];  // byte address, wraps.
    assign fetch_idx = fetch_addr[`LEN_IMEM_ADDR+1:2];

    always_ff @(posedge clk) begin
        if (grant_load) begin
            mem[load_idx] <= load_data;
        end
        if (grant_fetch) begin
            instr <= mem[fetch_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= grant_fetch;
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/core_pkg.sv
design/decode.sv
design/context_manager.sv
design/instr_store.sv
design/inst_window.sv
design/frontend_top.sv
testbench/tb_frontend.sv

/* run.sh */
#!/bin/sh
# Build the frontend testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_frontend -o sim_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_frontend > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* testbench/tb_frontend.sv */
`include "core_macros.svh"

`default_nettype none

module tb_frontend
    import core_pkg::*;
();

    localparam int PROG_WORDS = 64;
    localparam int TIMEOUT    = PROG_WORDS * `NUM_CONTEXT * 20;

    logic                 clk;
    logic                 rst_n;
    logic                 load_en;
    logic [`LEN_WORD-1:0] load_addr;
    logic [`LEN_INST-1:0] load_data;
    logic                 pop;
    dec_entry_t           head;
    logic                 not_empty;
    logic                 idle;

    logic [31:0]             prog [PROG_WORDS];
    logic [`NUM_CONTEXT-1:0] m_active;
    logic [31:0]             exp_pc [`NUM_CONTEXT];
    int                      popped;
    int                      cycles;

    frontend_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // timeout
    // ==============================
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("** FAIL **");
                $fatal(1, "run did not finish within %0d cycles", TIMEOUT);
            end
        end
    end

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            stop_run();
        end
    endtask

    // reference decode, context fields left at zero.
    function automatic dec_entry_t model_decode(input logic [31:0] ins, input logic [31:0] pc);
        dec_entry_t e;
        logic [6:0] op;
        logic [6:0] f7;
        logic       mem;
        logic       io;
        logic       fl;
        op = ins[6:0];
        e  = '0;
        case (op)
            OP_ALU:                               e.exec_type = ins[25] ? EX_ALU_EXT : EX_ALU;
            OP_ALUI:                              e.exec_type = EX_ALU;
            OP_FPU:                               e.exec_type = EX_FPU;
            OP_MEML, OP_MEMS, OP_FMEML, OP_FMEMS: e.exec_type = EX_MEM;
            OP_JALR:                              e.exec_type = EX_JUMP;
            OP_BRANCH:                            e.exec_type = EX_BRANCH;
            OP_LUI, OP_AUIPC, OP_JAL:             e.exec_type = EX_SUBST;
            OP_INPUT, OP_OUTPUT:                  e.exec_type = EX_IO;
            default:                              e.exec_type = EX_NONE;
        endcase
        mem     = (e.exec_type == EX_MEM);
        io      = (e.exec_type == EX_IO);
        e.func3 = (e.exec_type == EX_SUBST) ? 3'b0 : ins[14:12];
        f7      = ins[31:25];
        if (e.exec_type inside {EX_MEM, EX_JUMP, EX_BRANCH, EX_SUBST}) f7 = '0;
        if (op == OP_ALUI && ins[13:12] != 2'b01) f7 = '0;
        e.func7 = f7;
        fl = (op inside {OP_FPU, OP_FMEML, OP_FMEMS}) || (io && f7[5]);
        e.rs1.used = !(op inside {OP_LUI, OP_JAL, OP_AUIPC, OP_INPUT});
        e.rs2.used = (op inside {OP_ALU, OP_BRANCH, OP_MEMS, OP_FMEMS}) || (op == OP_FPU && !f7[5]);
        e.rd.used  = !(op inside {OP_MEMS, OP_FMEMS, OP_OUTPUT, OP_BRANCH});
        if (e.rs1.used)
            e.rs1.addr = {fl & ~mem & (~f7[6] | (f7[3] ^ f7[4]) | io), ins[19:15]};
        if (e.rs2.used)
            e.rs2.addr = {fl, ins[24:20]};
        if (e.rd.used)
            e.rd.addr = {fl & (~f7[6] | ~(f7[3] ^ f7[4]) | io), ins[11:7]};
        case (op)
            OP_ALUI, OP_MEML, OP_FMEML: e.imm = {{20{ins[31]}}, ins[31:20]};
            OP_MEMS, OP_FMEMS:          e.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            OP_JAL, OP_JALR:            e.imm = pc + 32'd4;
            OP_LUI:                     e.imm = {ins[31:12], 12'b0};
            OP_AUIPC:                   e.imm = pc + {ins[31:12], 12'b0};
            default:                    e.imm = '0;
        endcase
        e.io_type = (io | mem) & ins[5];
        return e;
    endfunction

    function automatic logic [31:0] taken_pc(input logic [31:0] ins, input logic [31:0] pc);
        if (ins[6:0] == OP_JAL)
            return pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        if (ins[6:0] == OP_BRANCH)
            return pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        return pc + 32'd4;
    endfunction

    // forward-only control flow, the last word always ends the path.
    task automatic build_program();
        opcode_e     ops [14];
        logic [31:0] ins;
        logic [11:0] off;
        int          k;
        ops = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_MEML, OP_MEMS,
                OP_ALUI, OP_ALU, OP_FMEML, OP_FMEMS, OP_FPU, OP_INPUT, OP_OUTPUT};
        for (int i = 0; i < PROG_WORDS; i++) begin
            ins = {$urandom() >> 7, 7'b0} | 32'(ops[$urandom_range(13)]);
            k   = 1 + $urandom_range(4);
            if (i + k > PROG_WORDS - 1) k = PROG_WORDS - 1 - i;
            off = 12'(k * 4);
            if (ins[6:0] == OP_BRANCH)
                ins = {1'b0, off[10:5], ins[24:12], off[4:1], 1'b0, ins[6:0]};
            if (ins[6:0] == OP_JAL)
                ins = {1'b0, off[10:1], 9'b0, ins[11:0]};
            if (i == PROG_WORDS - 1 || (k == 0 && ins[6:0] inside {OP_JAL, OP_BRANCH}))
                ins = {ins[31:7], 7'(OP_JALR)};
            prog[i] = ins;
        end
    endtask

    // replay the context manager in decode order.
    task automatic check_entry(input dec_entry_t h);
        dec_entry_t              e;
        logic [`LEN_CONTEXT-1:0] ctx;
        logic [`LEN_CONTEXT-1:0] low_free;
        logic                    any_free;
        logic [31:0]             ins;
        ctx = h.context_id;
        if (!m_active[ctx]) begin
            $display("context %0d delivered an entry while it was free", ctx);
            stop_run();
        end
        compare("pc", exp_pc[ctx], h.pc);
        if (h.pc[31:2] >= PROG_WORDS) begin
            $display("entry pc %0h lies outside the program", h.pc);
            stop_run();
        end
        ins = prog[h.pc[31:2]];
        e   = model_decode(ins, h.pc);
        compare("exec_type", e.exec_type, h.exec_type);
        compare("rs1", e.rs1, h.rs1);
        compare("rs2", e.rs2, h.rs2);
        compare("rd", e.rd, h.rd);
        compare("imm", e.imm, h.imm);
        compare("io_type", e.io_type, h.io_type);
        compare("func3", e.func3, h.func3);
        compare("func7", e.func7, h.func7);
        compare("context_b_f", ctx, h.context_b_f);
        low_free = '0;
        any_free = 1'b0;
        for (int i = `NUM_CONTEXT - 1; i >= 0; i--) begin
            if (!m_active[i]) begin
                low_free = i[`LEN_CONTEXT-1:0];
                any_free = 1'b1;
            end
        end
        compare("context_b_t", low_free, h.context_b_t);
        if (e.exec_type == EX_BRANCH) begin
            if (any_free) begin  // no free context means a refetch.
                m_active[low_free] = 1'b1;
                exp_pc[low_free]   = taken_pc(ins, h.pc);
                exp_pc[ctx]        = h.pc + 32'd4;
            end
        end else if (e.exec_type inside {EX_JUMP, EX_NONE}) begin
            m_active[ctx] = 1'b0;
        end else begin
            exp_pc[ctx] = taken_pc(ins, h.pc);
        end
        popped++;
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int stall_left;
        int step;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        pop       = 1'b0;
        popped    = 0;
        m_active  = `NUM_CONTEXT'(1);
        for (int i = 0; i < `NUM_CONTEXT; i++) exp_pc[i] = '0;
        void'($urandom(32'he7ed));
        build_program();

        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            if (i == 3) rst_n = 1'b1;  // four reset cycles.
            load_en   = 1'b1;
            load_addr = 32'(i * 4);
            load_data = prog[i];
        end
        @(negedge clk);
        load_en    = 1'b0;
        stall_left = 0;
        step       = 0;

        forever begin
            if (idle && !not_empty) break;
            step++;
            // loads mid-run into words that no path reaches.
            load_en   = (step >= 4 && step < 10);
            load_addr = 32'((200 + step) * 4);
            load_data = $urandom();
            if (stall_left > 0) begin
                stall_left--;
                pop = 1'b0;
            end else if ($urandom_range(39) == 0) begin
                stall_left = 20 + $urandom_range(19);
                pop = 1'b0;
            end else begin
                pop = ($urandom_range(2) != 0);
            end
            if (pop && not_empty) check_entry(head);
            @(negedge clk);
        end
        pop     = 1'b0;
        load_en = 1'b0;

        if (m_active == '0 && popped > 0) begin
            $display("%0d entries checked", popped);
            $display("** PASS **");
            $finish;
        end else begin
            $display("run went idle with model contexts %b still active", m_active);
            $display("** FAIL **");
            $fatal(1, "stopping at first error");
        end
    end

endmodule

`default_nettype wire
